// ==== Makefile ====
TOP = bpTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f $(wildcard src/*.sv src/*.svh test/*.sv)
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+src
src/bpPkg.sv
src/satCounterTable.sv
src/gshareDir.sv
src/bimodalDir.sv
src/tournamentChooser.sv
src/branchPredictor.sv
test/bpTb.sv

// ==== src/bimodalDir.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module bimodalDir (
  input  logic      clk,
  input  logic      rstN,
  input  bpPkg::pcT lookupPc,
  input  logic      resolveValid,
  input  bpPkg::pcT resolvePc,
  input  logic      resolveTaken,
  output logic      bimodalTaken,
  output logic      bimodalResolveTaken
);
  import bpPkg::*;

  localparam int idxBits = `BP_PC_IDX_BITS;

  ctr2T lookupCtr;
  ctr2T resolveCtr;

  // Indexed by PC word bits only, so each branch learns its own bias
  // No history is involved and aliasing is purely by address
  satCounterTable #(
    .idxBits  (idxBits),
    .resetCtr (weakNotTaken)
  ) bhtTable (
    .clk      (clk),
    .rstN     (rstN),
    .rdIdx    (lookupPc[idxBits+1:2]),
    .updIdx   (resolvePc[idxBits+1:2]),
    .updValid (resolveValid),
    .updTaken (resolveTaken),
    .updWrite (1'b1),
    .rdCtr    (lookupCtr),
    .updCtr   (resolveCtr)
  );

  assign bimodalTaken        = lookupCtr[1];
  // The resolve-side opinion lets the chooser see who would have been right
  assign bimodalResolveTaken = resolveCtr[1];

endmodule

// ==== src/bpPkg.sv ====
package bpPkg;

`include "bp_defs.svh"

  // Two-bit saturating counter
  // The upper bit is the taken/not-taken prediction
  typedef enum logic [1:0] {
    strongNotTaken = 2'b00,
    weakNotTaken   = 2'b01,
    weakTaken      = 2'b10,
    strongTaken    = 2'b11
  } ctr2T;

  // Global history, newest outcome in the top bit
  // Older outcomes move toward bit 0 on every shift
  typedef logic [`BP_GHR_BITS-1:0] ghrT;

  // Program counter of a branch
  typedef logic [`BP_PC_BITS-1:0] pcT;

endpackage

// ==== src/bp_defs.svh ====
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Length of the global history register
// This is also the width of the gshare table index
`define BP_GHR_BITS 8

// Index width shared by the bimodal table and the chooser table
`define BP_PC_IDX_BITS 6

// Width of a fetch or resolve PC
`define BP_PC_BITS 32

`endif

// ==== src/branchPredictor.sv ====
`timescale 1ns/1ps

module branchPredictor (
  input  logic       clk,
  input  logic       rstN,
  input  logic       lookupValid,
  input  bpPkg::pcT  lookupPc,
  input  logic       resolveValid,
  input  bpPkg::pcT  resolvePc,
  input  logic       resolveTaken,
  input  logic       resolvePredTaken,
  input  bpPkg::ghrT resolveGhr,
  output logic       predTaken,
  output bpPkg::ghrT predGhr,
  output logic       mispredict
);

  // Component predictions at lookup and at resolve
  logic gshareTaken;
  logic gshareResolveTaken;
  logic bimodalTaken;
  logic bimodalResolveTaken;

  // The final prediction is shifted into the history, not gshare's own answer
  // No loop forms since gshareTaken only depends on the history and lookupPc
  gshareDir gshareDir_i (
    .clk                (clk),
    .rstN               (rstN),
    .lookupValid        (lookupValid),
    .lookupPc           (lookupPc),
    .finalTaken         (predTaken),
    .resolveValid       (resolveValid),
    .resolvePc          (resolvePc),
    .resolveTaken       (resolveTaken),
    .resolvePredTaken   (resolvePredTaken),
    .resolveGhr         (resolveGhr),
    .gshareTaken        (gshareTaken),
    .ghr                (predGhr),
    .gshareResolveTaken (gshareResolveTaken),
    .mispredict         (mispredict)
  );

  bimodalDir bimodalDir_i (
    .clk                 (clk),
    .rstN                (rstN),
    .lookupPc            (lookupPc),
    .resolveValid        (resolveValid),
    .resolvePc           (resolvePc),
    .resolveTaken        (resolveTaken),
    .bimodalTaken        (bimodalTaken),
    .bimodalResolveTaken (bimodalResolveTaken)
  );

  tournamentChooser tournamentChooser_i (
    .clk                 (clk),
    .rstN                (rstN),
    .lookupPc            (lookupPc),
    .gshareTaken         (gshareTaken),
    .bimodalTaken        (bimodalTaken),
    .resolveValid        (resolveValid),
    .resolvePc           (resolvePc),
    .resolveTaken        (resolveTaken),
    .gshareResolveTaken  (gshareResolveTaken),
    .bimodalResolveTaken (bimodalResolveTaken),
    .predTaken           (predTaken)
  );

endmodule

// ==== src/gshareDir.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module gshareDir (
  input  logic        clk,
  input  logic        rstN,
  input  logic        lookupValid,
  input  bpPkg::pcT   lookupPc,
  input  logic        finalTaken,
  input  logic        resolveValid,
  input  bpPkg::pcT   resolvePc,
  input  logic        resolveTaken,
  input  logic        resolvePredTaken,
  input  bpPkg::ghrT  resolveGhr,
  output logic        gshareTaken,
  output bpPkg::ghrT  ghr,
  output logic        gshareResolveTaken,
  output logic        mispredict
);
  import bpPkg::*;

  localparam int ghrBits = `BP_GHR_BITS;

  logic [ghrBits-1:0] lookupIdx;
  logic [ghrBits-1:0] resolveIdx;
  ctr2T               lookupCtr;
  ctr2T               resolveCtr;
  ghrT                repairGhr;

  // History XOR PC word bits with PC bit 1 folded into the top index bit
  function automatic logic [ghrBits-1:0] hashIdx(ghrT hist, pcT pc);
    return hist ^ {pc[ghrBits+1] ^ pc[1], pc[ghrBits:2]};
  endfunction

  assign lookupIdx  = hashIdx(ghr, lookupPc);
  // Training must hit the entry the prediction came from, so use the snapshot
  assign resolveIdx = hashIdx(resolveGhr, resolvePc);

  satCounterTable #(
    .idxBits  (ghrBits),
    .resetCtr (weakNotTaken)
  ) phtTable (
    .clk      (clk),
    .rstN     (rstN),
    .rdIdx    (lookupIdx),
    .updIdx   (resolveIdx),
    .updValid (resolveValid),
    .updTaken (resolveTaken),
    .updWrite (1'b1),
    .rdCtr    (lookupCtr),
    .updCtr   (resolveCtr)
  );

  assign gshareTaken        = lookupCtr[1];
  assign gshareResolveTaken = resolveCtr[1];

  ////////////////////////////////////////////////////////////////////////////
  // Speculative history and repair
  ////////////////////////////////////////////////////////////////////////////

  assign mispredict = resolveValid && (resolveTaken != resolvePredTaken);

  // The snapshot with the real outcome shifted in is the correct history
  assign repairGhr = {resolveTaken, resolveGhr[ghrBits-1:1]};

  // A repair wins over a same-cycle lookup, whose shift is on the wrong path
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ghr <= '0;
    end else if (mispredict) begin
      ghr <= repairGhr;
    end else if (lookupValid) begin
      ghr <= {finalTaken, ghr[ghrBits-1:1]};
    end
  end

  // The repair and the table training both rely on a fully known resolve
  resolveKnownA: assert property (
    @(posedge clk) disable iff (!rstN)
    resolveValid |-> !$isunknown({resolveTaken, resolvePredTaken, resolveGhr})
  ) else $error("gshareDir resolve with unknown outcome or history");

endmodule

// ==== src/satCounterTable.sv ====
`timescale 1ns/1ps

module satCounterTable #(
  parameter int          idxBits  = 6,
  parameter bpPkg::ctr2T resetCtr = bpPkg::weakNotTaken
) (
  input  logic               clk,
  input  logic               rstN,
  input  logic [idxBits-1:0] rdIdx,
  input  logic [idxBits-1:0] updIdx,
  input  logic               updValid,
  input  logic               updTaken,
  input  logic               updWrite,
  output bpPkg::ctr2T        rdCtr,
  output bpPkg::ctr2T        updCtr
);
  import bpPkg::*;

  localparam int depth = 2 ** idxBits;

  ctr2T ctrMem [depth];

  // One saturating step of a counter toward the observed direction
  function automatic ctr2T stepCtr(ctr2T cur, logic taken);
    ctr2T nxt;
    case (cur)
      strongNotTaken: nxt = taken ? weakNotTaken : strongNotTaken;
      weakNotTaken:   nxt = taken ? weakTaken    : strongNotTaken;
      weakTaken:      nxt = taken ? strongTaken  : weakNotTaken;
      default:        nxt = taken ? strongTaken  : weakTaken;
    endcase
    return nxt;
  endfunction

  // Both read ports are asynchronous
  // A lookup sees what was written up to the previous edge
  assign rdCtr  = ctrMem[rdIdx];
  assign updCtr = ctrMem[updIdx];

  ////////////////////////////////////////////////////////////////////////////
  // Training write port
  ////////////////////////////////////////////////////////////////////////////

  // The new value is derived from the counter read this same cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < depth; i++) begin
        ctrMem[i] <= resetCtr;
      end
    end else if (updValid && updWrite) begin
      ctrMem[updIdx] <= stepCtr(updCtr, updTaken);
    end
  end

  // A write with an unknown index would corrupt an unpredictable entry
  updIdxKnownA: assert property (
    @(posedge clk) disable iff (!rstN)
    (updValid && updWrite) |-> !$isunknown(updIdx)
  ) else $error("satCounterTable write with unknown index");

endmodule

// ==== src/tournamentChooser.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module tournamentChooser (
  input  logic      clk,
  input  logic      rstN,
  input  bpPkg::pcT lookupPc,
  input  logic      gshareTaken,
  input  logic      bimodalTaken,
  input  logic      resolveValid,
  input  bpPkg::pcT resolvePc,
  input  logic      resolveTaken,
  input  logic      gshareResolveTaken,
  input  logic      bimodalResolveTaken,
  output logic      predTaken
);
  import bpPkg::*;

  localparam int idxBits = `BP_PC_IDX_BITS;

  ctr2T lookupCtr;
  logic gshareRight;
  logic bimodalRight;
  logic chooserWrite;

  ////////////////////////////////////////////////////////////////////////////
  // Selection at lookup
  ////////////////////////////////////////////////////////////////////////////

  // Upper bit set means gshare is trusted for this PC
  assign predTaken = lookupCtr[1] ? gshareTaken : bimodalTaken;

  ////////////////////////////////////////////////////////////////////////////
  // Training at resolve
  ////////////////////////////////////////////////////////////////////////////

  assign gshareRight  = (gshareResolveTaken == resolveTaken);
  assign bimodalRight = (bimodalResolveTaken == resolveTaken);

  // When both were right or both wrong there is nothing to learn
  assign chooserWrite = gshareRight ^ bimodalRight;

  // Stepping up moves trust toward gshare
  // Out of reset the chooser leans weakly toward gshare
  satCounterTable #(
    .idxBits  (idxBits),
    .resetCtr (weakTaken)
  ) chooserTable (
    .clk      (clk),
    .rstN     (rstN),
    .rdIdx    (lookupPc[idxBits+1:2]),
    .updIdx   (resolvePc[idxBits+1:2]),
    .updValid (resolveValid),
    .updTaken (gshareRight),
    .updWrite (chooserWrite),
    .rdCtr    (lookupCtr),
    .updCtr   ()
  );

  // Training needs both component opinions and the outcome to be known
  trainKnownA: assert property (
    @(posedge clk) disable iff (!rstN)
    resolveValid |-> !$isunknown({resolveTaken, gshareResolveTaken, bimodalResolveTaken})
  ) else $error("tournamentChooser trained with unknown component opinions");

endmodule

// ==== test/bpTb.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module bpTb;
  import bpPkg::*;

  localparam int gb = `BP_GHR_BITS;
  localparam int pb = `BP_PC_IDX_BITS;

  logic clk = 1'b0;
  logic rstN, lookupValid, resolveValid, resolveTaken, resolvePredTaken;
  logic predTaken, mispredict;
  pcT   lookupPc, resolvePc;
  ghrT  resolveGhr, predGhr;

  // Reference copies of the gshare, bimodal and chooser tables and the history
  ctr2T gTab [2**gb];
  ctr2T bTab [2**pb];
  ctr2T cTab [2**pb];
  ghrT  mGhr;
  // What the model expected in the most recent cycle
  logic lastPred;
  ghrT  lastGhr;
  int   seedDummy;

  branchPredictor branchPredictor_i (.*);

  always #5 clk = ~clk;

  function automatic ctr2T nextCounter(ctr2T c, logic up);
    ctr2T r;
    r = c;
    if (up && c != strongTaken) r = ctr2T'(c + 2'd1);
    else if (!up && c != strongNotTaken) r = ctr2T'(c - 2'd1);
    return r;
  endfunction

  // Word-address bits of the PC with the top bit folded with PC bit 1 and XORed with history
  function automatic logic [gb-1:0] gshareIndex(ghrT h, pcT pc);
    logic [gb-1:0] pcBits;
    pcBits = pc[gb+1:2];
    pcBits[gb-1] = pcBits[gb-1] ^ pc[1];
    return h ^ pcBits;
  endfunction

  function automatic logic [pb-1:0] tableIndex(pcT pc);
    return pc[pb+1:2];
  endfunction

  task automatic abortRun(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("** FAIL **");
    $fatal(1, "run aborted");
  endtask

  task automatic checkTaken(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "%s check failed", name);
    end
  endtask

  task automatic checkGhr(input string name, input ghrT got, input ghrT exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "%s check failed", name);
    end
  endtask

  task automatic checkMispredict(input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t mispredict got=%b expected=%b", $time, got, exp);
      $display("** FAIL **");
      $fatal(1, "mispredict check failed");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One clock cycle that drives, compares at the falling edge and advances the model
  ////////////////////////////////////////////////////////////////////////////

  task automatic runCycle(input logic lv, input pcT lpc, input logic rv, input pcT rpc,
                          input logic rt, input logic rpt, input ghrT rghr);
    logic gR, bR, expPred, expMis;
    logic [gb-1:0] gi;
    logic [pb-1:0] pi;
    @(posedge clk);
    lookupValid      <= lv;
    lookupPc         <= lpc;
    resolveValid     <= rv;
    resolvePc        <= rpc;
    resolveTaken     <= rt;
    resolvePredTaken <= rpt;
    resolveGhr       <= rghr;
    @(negedge clk);
    // The chooser's upper bit picks gshare, otherwise bimodal answers
    pi = tableIndex(lpc);
    expPred = cTab[pi][1] ? gTab[gshareIndex(mGhr, lpc)][1] : bTab[pi][1];
    expMis = rv && (rt != rpt);
    checkTaken("predTaken", predTaken, expPred);
    checkGhr("predGhr", predGhr, mGhr);
    checkMispredict(mispredict, expMis);
    lastPred = expPred;
    lastGhr = mGhr;
    // Training reads every counter before any of them is written
    if (rv) begin
      gi = gshareIndex(rghr, rpc);
      pi = tableIndex(rpc);
      gR = gTab[gi][1];
      bR = bTab[pi][1];
      gTab[gi] = nextCounter(gTab[gi], rt);
      bTab[pi] = nextCounter(bTab[pi], rt);
      if ((gR == rt) != (bR == rt)) cTab[pi] = nextCounter(cTab[pi], gR == rt);
    end
    // Repair beats the speculative shift of a same-cycle lookup
    if (expMis) mGhr = {rt, rghr[gb-1:1]};
    else if (lv) mGhr = {expPred, mGhr[gb-1:1]};
  endtask

  task automatic doLookup(input pcT pc);
    runCycle(1'b1, pc, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic doResolve(input pcT pc, input logic taken, input logic given, input ghrT g);
    runCycle(1'b0, pc, 1'b1, pc, taken, given, g);
  endtask

  // Shows the prediction for a PC without moving the history
  task automatic peekPredict(input pcT pc);
    runCycle(1'b0, pc, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic resetDefaults();
    for (int i = 0; i < 4; i++) begin
      doLookup(32'h100 + 4 * i);
      checkTaken("predTaken", predTaken, 1'b0);
      checkGhr("predGhr", predGhr, '0);
      checkMispredict(mispredict, 1'b0);
    end
  endtask

  task automatic historyShift();
    pcT   pc;
    logic prevPred;
    ghrT  prevGhr;
    pc = 32'h200;
    // Two correct taken resolves make this PC taken under the current history
    doResolve(pc, 1'b1, 1'b1, mGhr);
    doResolve(pc, 1'b1, 1'b1, mGhr);
    for (int i = 0; i < 8; i++) begin
      doLookup(pc + 32'(4 * (i % 3)));
      if (i == 0) checkTaken("predTaken", predTaken, 1'b1);
      else checkGhr("predGhr", predGhr, {prevPred, prevGhr[gb-1:1]});
      prevPred = lastPred;
      prevGhr = lastGhr;
    end
  endtask

  task automatic mispredictRepair();
    ghrT snap;
    snap = ghrT'('hB2);
    runCycle(1'b1, 32'h300, 1'b1, 32'h340, 1'b1, 1'b0, snap);
    checkMispredict(mispredict, 1'b1);
    peekPredict(32'h300);
    checkGhr("predGhr", predGhr, {1'b1, snap[gb-1:1]});
    runCycle(1'b1, 32'h300, 1'b1, 32'h340, 1'b0, 1'b0, snap);
    checkMispredict(mispredict, 1'b0);
    peekPredict(32'h300);
  endtask

  task automatic counterSaturation();
    pcT         pc;
    ghrT        g;
    logic [8:0] outs;
    logic [8:0] expTaken;
    pc = 32'hF0;
    g = mGhr;
    // Bit i is the outcome of step i and the prediction seen after it
    outs = 9'b001111000;
    expTaken = 9'b011110000;
    for (int i = 0; i < 9; i++) begin
      doResolve(pc, outs[i], outs[i], g);
      peekPredict(pc);
      checkTaken("predTaken", predTaken, expTaken[i]);
    end
  endtask

  task automatic chooserSelection();
    pcT          pc, other;
    logic        pred;
    ghrT         snap;
    int          misses;
    logic [31:0] r;
    pc = 32'h184;
    other = 32'h2C8;
    misses = 0;
    // Always-taken branch while a random branch scrambles the history
    for (int i = 0; i < 24; i++) begin
      doLookup(pc);
      pred = lastPred;
      snap = lastGhr;
      doResolve(pc, 1'b1, pred, snap);
      if (mispredict) misses++;
      doLookup(other);
      pred = lastPred;
      snap = lastGhr;
      r = $urandom();
      doResolve(other, r[0], pred, snap);
    end
    if (misses > 2) abortRun("biased branch kept mispredicting instead of trusting bimodal");
    // Alternating branch on the same PC, which only gshare can follow
    for (int i = 0; i < 40; i++) begin
      doLookup(pc);
      pred = lastPred;
      snap = lastGhr;
      doResolve(pc, (i % 2) == 0, pred, snap);
      if (i >= 30) checkMispredict(mispredict, 1'b0);
    end
  endtask

  task automatic randomTraffic();
    pcT          qPc [$];
    logic        qPred [$];
    ghrT         qGhr [$];
    logic [31:0] r;
    pcT          lpc, rpc;
    logic        rv, rpt;
    ghrT         rg;
    for (int n = 0; n < 300; n++) begin
      r = $urandom();
      lpc = 32'h1000;
      lpc[6:2] = r[5:1];
      lpc[1] = r[6];
      rv = r[7] && (qPc.size() > 0);
      rpc = '0;
      rpt = 1'b0;
      rg = '0;
      if (rv) begin
        rpc = qPc.pop_front();
        rpt = qPred.pop_front();
        rg = qGhr.pop_front();
      end
      runCycle(r[0], lpc, rv, rpc, r[8], rpt, rg);
      // Resolves later use exactly what the model handed out at lookup
      if (r[0]) begin
        qPc.push_back(lpc);
        qPred.push_back(lastPred);
        qGhr.push_back(lastGhr);
      end
    end
  endtask

  initial begin
    int waitCycles;
    seedDummy = $urandom(59);
    rstN             <= 1'b0;
    lookupValid      <= 1'b0;
    lookupPc         <= '0;
    resolveValid     <= 1'b0;
    resolvePc        <= '0;
    resolveTaken     <= 1'b0;
    resolvePredTaken <= 1'b0;
    resolveGhr       <= '0;
    for (int i = 0; i < 2**gb; i++) gTab[i] = weakNotTaken;
    for (int i = 0; i < 2**pb; i++) begin
      bTab[i] = weakNotTaken;
      cTab[i] = weakTaken;
    end
    mGhr = '0;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    waitCycles = 0;
    @(negedge clk);
    while (mispredict !== 1'b0 || predGhr !== '0) begin
      if (waitCycles == 10) abortRun("predictor outputs did not settle after reset");
      waitCycles++;
      @(negedge clk);
    end
    resetDefaults();
    historyShift();
    mispredictRepair();
    counterSaturation();
    chooserSelection();
    randomTraffic();
    $display("** PASS **");
    $finish;
  end

endmodule
